// File: files.f
+incdir+bench
src/review_pkg.sv
src/op_result_if.sv
src/score_if.sv
src/operation_unit.sv
src/answer_formatter.sv
src/score_tally.sv
src/leader_rank.sv
src/review_top.sv
bench/review_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = review_tb
FILELIST  = files.f
LOG       = sim.log
PASS_MSG  = All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/review_checks.svh
`ifndef REVIEW_CHECKS_SVH
`define REVIEW_CHECKS_SVH

// reports a mismatch between a DUT value and its expected value
task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want_v);
    if (got !== want_v) begin
        $display("error: %s got %h expected %h", name, got, want_v);
        err_count++;
    end
endtask

// answer bytes {ans_hi, ans_lo} for one question record
function automatic logic [15:0] expected_answer(input logic [2:0] cat, input logic [1:0] op,
                                                input logic [7:0] a, input logic [7:0] b);
    int         ai;
    int         bi;
    int         s;
    int         m;
    logic [7:0] r;
    bit         a_set;
    bit         b_set;
    bit         l;
    ai    = int'(a);
    bi    = int'(b);
    a_set = (a != 8'd0);
    b_set = (b != 8'd0);
    case (cat)
        3'd1: begin   // base conversion of a
            case (op)
                2'd0:    return {4'(ai / 64), 4'((ai / 8) % 8), 4'(ai % 8), 4'h0};
                2'd1:    return {4'(ai / 100), 4'((ai / 10) % 10), 4'(ai % 10), 4'h0};
                2'd2:    return {a, 8'h00};
                default: return 16'h0000;
            endcase
        end
        3'd2: begin
            if (op > 2'd1) begin
                return 16'h0000;
            end
            r = (op == 2'd0) ? a + b : a - b;                  // wraps to 8 bits
            s = (int'(r) > 127) ? int'(r) - 256 : int'(r);     // two's complement value
            m = (s < 0) ? -s : s;
            return {(s < 0), 3'b000, 4'(m / 100), 4'((m / 10) % 10), 4'(m % 10)};
        end
        3'd3: begin
            if (bi >= 8) begin
                r = (op == 2'd1 && a[7]) ? 8'hff : 8'h00;
            end else if (op == 2'd1) begin
                r = (a >> bi) | (a[7] ? ~(8'hff >> bi) : 8'h00);   // sign fill
            end else if (op == 2'd3) begin
                r = a >> bi;
            end else begin
                r = a << bi;
            end
            return {r, 8'h00};
        end
        3'd4: begin
            case (op)
                2'd0:    return {a & b, 8'h00};
                2'd1:    return {a | b, 8'h00};
                2'd2:    return {~a, 8'h00};
                default: return {a ^ b, 8'h00};
            endcase
        end
        3'd5: begin
            case (op)
                2'd0:    l = a_set && b_set;
                2'd1:    l = a_set || b_set;
                2'd2:    l = !a_set;
                default: l = a_set ^ b_set;
            endcase
            return {(l ? 8'hff : 8'h00), 8'h00};   // bit spread over the byte
        end
        default: return 16'h0000;
    endcase
endfunction

// leading live player: most correct answers, then least time, then lowest index
function automatic int expected_winner(input int cnt [4], input int tm [4], input int players);
    int best;
    best = 0;
    for (int i = 1; i < players; i++) begin
        if (cnt[i] > cnt[best] || (cnt[i] == cnt[best] && tm[i] < tm[best])) begin
            best = i;
        end
    end
    return best;
endfunction

`endif

// File: bench/review_tb.sv
`timescale 1ns/100ps

module review_tb;

    localparam int TIMEOUT = 200;   // cycles per wait

    logic       clk;
    logic       arst_n;
    logic       q_valid;
    logic       q_ready;
    logic [2:0] q_category;
    logic [1:0] q_op;
    logic [7:0] q_a;
    logic [7:0] q_b;
    logic       ans_valid;
    logic       ans_ready;
    logic [7:0] ans_hi;
    logic [7:0] ans_lo;
    logic       sc_clear;
    logic [2:0] sc_players;
    logic       sc_valid;
    logic [1:0] sc_player;
    logic       sc_correct;
    logic [4:0] sc_time;
    logic [1:0] winner;
    logic       winner_valid;

    int          err_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle = 0;      // rising edges so far
    logic [15:0] exp_q [$];      // expected answers in question order
    int          acc_q [$];      // acceptance edge of each question
    bit          bp_on = 1'b0;
    bit          lat_check = 1'b0;
    bit          stalled = 1'b0;
    logic [15:0] held_ans;
    logic [15:0] want;
    int          acc_edge;
    int          m_count [4];    // score model
    int          m_time [4];
    int          m_players;
    bit          m_valid;
    int          mark;

    `include "review_checks.svh"

    review_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle++;

    // answer back-pressure
    initial begin
        ans_ready = 1'b1;
        forever begin
            @(posedge clk);
            #10;
            ans_ready = bp_on ? ($urandom % 4 != 0) : 1'b1;
        end
    end

    // answer checker, sampled mid-cycle
    always @(negedge clk) begin
        if (stalled) begin
            compare("ans_valid", 32'(ans_valid), 32'(1'b1));
            compare("ans_hi", 32'(ans_hi), 32'(held_ans[15:8]));
            compare("ans_lo", 32'(ans_lo), 32'(held_ans[7:0]));
        end
        stalled = 1'b0;
        if (arst_n && ans_valid && !ans_ready) begin
            stalled  = 1'b1;
            held_ans = {ans_hi, ans_lo};
        end else if (arst_n && ans_valid) begin
            if (exp_q.size() == 0) begin
                $display("an answer arrived with no question pending");
                err_count++;
            end else begin
                want     = exp_q.pop_front();
                acc_edge = acc_q.pop_front();
                compare("ans_hi", 32'(ans_hi), 32'(want[15:8]));
                compare("ans_lo", 32'(ans_lo), 32'(want[7:0]));
                if (lat_check) begin
                    compare("ans_latency", 32'(cycle + 1), 32'(acc_edge + 2));  // transfer edge
                end
            end
        end
    end

    task automatic send_question(input logic [2:0] cat, input logic [1:0] op,
                                 input logic [7:0] a, input logic [7:0] b,
                                 input logic [15:0] exp_ans);
        int waited;
        q_valid    = 1'b1;
        q_category = cat;
        q_op       = op;
        q_a        = a;
        q_b        = b;
        waited     = 0;
        @(negedge clk);
        while (!q_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (q_ready) begin
            exp_q.push_back(exp_ans);
            acc_q.push_back(cycle + 1);   // taken at the coming edge
        end else begin
            $display("a question was never accepted");
            err_count++;
        end
        @(posedge clk);
        #10;
        q_valid = 1'b0;
    endtask

    task automatic directed_question(input logic [2:0] cat, input logic [1:0] op,
                                     input logic [7:0] a, input logic [7:0] b,
                                     input logic [15:0] lit);
        compare("expected_answer", 32'(expected_answer(cat, op, a, b)), 32'(lit));
        send_question(cat, op, a, b, lit);
    endtask

    task automatic random_questions(input int n, input bit gaps);
        logic [2:0] cat;
        logic [1:0] op;
        logic [7:0] a;
        logic [7:0] b;
        int         idle;
        for (int i = 0; i < n; i++) begin
            cat = 3'($urandom);   // unused codes too
            op  = 2'($urandom);
            a   = 8'($urandom);
            b   = ($urandom % 4 == 0) ? 8'($urandom) : 8'($urandom % 10);
            send_question(cat, op, a, b, expected_answer(cat, op, a, b));
            idle = gaps ? int'($urandom % 3) : 0;
            repeat (idle) begin
                @(posedge clk);
                #10;
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d answers never arrived", exp_q.size());
            err_count++;
            exp_q.delete();
            acc_q.delete();
        end
    endtask

    task automatic clear_scores(input int players);
        int waited;
        sc_clear   = 1'b1;
        sc_players = 3'(players);
        for (int i = 0; i < 4; i++) begin
            m_count[i] = 0;
            m_time[i]  = 0;
        end
        m_players = (players < 1) ? 1 : ((players > 4) ? 4 : players);
        m_valid   = 1'b0;
        @(posedge clk);
        #10;
        sc_clear = 1'b0;
        waited   = 0;
        while (winner_valid !== 1'b0 && waited < TIMEOUT) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (winner_valid !== 1'b0) begin
            $display("winner_valid did not drop after a clear");
            err_count++;
        end
    endtask

    task automatic score_record(input int player, input bit correct, input int t);
        sc_valid   = 1'b1;
        sc_player  = 2'(player);
        sc_correct = correct;
        sc_time    = 5'(t);
        if (player < m_players) begin   // idle seats leave the model alone
            if (correct && m_count[player] < 63) begin
                m_count[player]++;
            end
            m_time[player] = (m_time[player] + t > 1023) ? 1023 : m_time[player] + t;
            m_valid = 1'b1;
        end
        @(posedge clk);
        #10;
        sc_valid = 1'b0;
        @(posedge clk);   // winner registered here
        @(negedge clk);
        compare("winner_valid", 32'(winner_valid), 32'(m_valid));
        if (m_valid) begin
            compare("winner", 32'(winner), 32'(expected_winner(m_count, m_time, m_players)));
        end
        @(posedge clk);
        #10;
    endtask

    task automatic end_test(input string name, input int start_errs);
        tests_run++;
        if (err_count == start_errs) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - start_errs);
        end
    endtask

    initial begin
        void'($urandom(68115));
        arst_n     = 1'b0;
        q_valid    = 1'b0;
        q_category = 3'd0;
        q_op       = 2'd0;
        q_a        = 8'd0;
        q_b        = 8'd0;
        sc_clear   = 1'b0;
        sc_players = 3'd4;
        sc_valid   = 1'b0;
        sc_player  = 2'd0;
        sc_correct = 1'b0;
        sc_time    = 5'd0;
        for (int i = 0; i < 4; i++) begin
            m_count[i] = 0;
            m_time[i]  = 0;
        end
        m_players = 4;
        m_valid   = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        arst_n = 1'b1;

        mark = err_count;
        compare("q_ready", 32'(q_ready), 32'(1'b1));
        compare("ans_valid", 32'(ans_valid), 32'(1'b0));
        compare("winner_valid", 32'(winner_valid), 32'(1'b0));
        end_test("reset", mark);

        mark      = err_count;
        lat_check = 1'b1;
        directed_question(3'd1, 2'd1, 8'd255, 8'd0, 16'h2550);    // decimal 255
        directed_question(3'd1, 2'd0, 8'd8, 8'd0, 16'h0100);      // octal 010
        directed_question(3'd1, 2'd2, 8'ha7, 8'd0, 16'ha700);
        directed_question(3'd2, 2'd0, 8'd100, 8'd100, 16'h8056);  // wraps to -56
        directed_question(3'd2, 2'd1, 8'd3, 8'd5, 16'h8002);
        wait_drain();
        end_test("directed", mark);

        mark = err_count;
        random_questions(200, 1'b0);
        wait_drain();
        end_test("random", mark);

        mark      = err_count;
        lat_check = 1'b0;
        bp_on     = 1'b1;
        random_questions(200, 1'b0);
        wait_drain();
        bp_on = 1'b0;
        end_test("backpressure", mark);

        mark      = err_count;
        lat_check = 1'b1;
        random_questions(60, 1'b1);
        wait_drain();
        lat_check = 1'b0;
        end_test("latency", mark);

        mark = err_count;
        clear_scores(3);
        for (int i = 0; i < 80; i++) begin
            score_record(int'($urandom % 4), 1'($urandom % 2), int'($urandom % 8));
        end
        end_test("scores", mark);

        mark = err_count;
        clear_scores(4);
        compare("winner_valid", 32'(winner_valid), 32'(1'b0));
        score_record(1, 1'b1, 3);
        score_record(2, 1'b1, 3);   // full tie stays with player 1
        score_record(0, 1'b1, 2);
        score_record(3, 1'b1, 0);
        end_test("clear", mark);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: src/review_top.sv
`timescale 1ns/100ps

module review_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     q_valid,
    output logic                     q_ready,
    input  logic [2:0]               q_category,
    input  review_pkg::op_sel_t      q_op,
    input  review_pkg::operand_t     q_a,
    input  review_pkg::operand_t     q_b,
    output logic                     ans_valid,
    input  logic                     ans_ready,
    output review_pkg::operand_t     ans_hi,
    output review_pkg::operand_t     ans_lo,
    input  logic                     sc_clear,
    input  logic [2:0]               sc_players,
    input  logic                     sc_valid,
    input  review_pkg::player_id_t   sc_player,
    input  logic                     sc_correct,
    input  review_pkg::answer_time_t sc_time,
    output review_pkg::player_id_t   winner,
    output logic                     winner_valid
);

    op_result_if res_bus ();
    score_if     score_bus ();

    operation_unit u_operation (
        .clk        (clk),
        .arst_n     (arst_n),
        .q_valid    (q_valid),
        .q_ready    (q_ready),
        .q_category (q_category),
        .q_op       (q_op),
        .q_a        (q_a),
        .q_b        (q_b),
        .res        (res_bus.source)
    );

    answer_formatter u_formatter (
        .clk       (clk),
        .arst_n    (arst_n),
        .res       (res_bus.sink),
        .ans_valid (ans_valid),
        .ans_hi    (ans_hi),
        .ans_lo    (ans_lo),
        .ans_ready (ans_ready)
    );

    score_tally u_tally (
        .clk        (clk),
        .arst_n     (arst_n),
        .sc_clear   (sc_clear),
        .sc_players (sc_players),
        .sc_valid   (sc_valid),
        .sc_player  (sc_player),
        .sc_correct (sc_correct),
        .sc_time    (sc_time),
        .scores     (score_bus.source)
    );

    leader_rank u_rank (
        .clk          (clk),
        .arst_n       (arst_n),
        .scores       (score_bus.sink),
        .winner       (winner),
        .winner_valid (winner_valid)
    );

endmodule

// File: src/leader_rank.sv
`timescale 1ns/100ps

module leader_rank (
    input  logic                   clk,
    input  logic                   arst_n,
    score_if.sink                  scores,
    output review_pkg::player_id_t winner,
    output logic                   winner_valid
);

    review_pkg::player_id_t best_idx;
    review_pkg::count_t     best_count;
    review_pkg::time_t      best_time;

    // strict compares keep the lower index on a full tie
    always_comb begin
        best_idx   = '0;   // player 0 is live for any player count
        best_count = scores.count[0];
        best_time  = scores.total_time[0];
        for (int i = 1; i < review_pkg::NUM_PLAYERS; i++) begin
            if (scores.live[i] &&
                (scores.count[i] > best_count ||
                 (scores.count[i] == best_count && scores.total_time[i] < best_time))) begin
                best_idx   = review_pkg::player_id_t'(i);
                best_count = scores.count[i];
                best_time  = scores.total_time[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            winner       <= '0;
            winner_valid <= 1'b0;
        end else if (scores.clear) begin
            winner       <= '0;
            winner_valid <= 1'b0;
        end else if (scores.update) begin
            winner       <= best_idx;
            winner_valid <= 1'b1;
        end
    end

    // live flags move one cycle ahead of the clear reaching this register
    a_winner_live: assert property (@(posedge clk) disable iff (!arst_n)
        winner_valid && !scores.clear |-> scores.live[winner]);

endmodule

// File: src/score_tally.sv
`timescale 1ns/100ps

module score_tally (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     sc_clear,
    input  logic [2:0]               sc_players,
    input  logic                     sc_valid,
    input  review_pkg::player_id_t   sc_player,
    input  logic                     sc_correct,
    input  review_pkg::answer_time_t sc_time,
    score_if.source                  scores
);

    review_pkg::count_t                 count_q [review_pkg::NUM_PLAYERS];
    review_pkg::time_t                  time_q  [review_pkg::NUM_PLAYERS];
    logic [2:0]                         players_q;
    logic [review_pkg::NUM_PLAYERS-1:0] live;
    logic                               rec_ok;
    logic [10:0]                        time_wide;

    for (genvar p = 0; p < review_pkg::NUM_PLAYERS; p++) begin : g_player
        assign live[p]                = 3'(p) < players_q;
        assign scores.count[p]        = count_q[p];
        assign scores.total_time[p]   = time_q[p];
    end
    assign scores.live = live;

    assign rec_ok    = sc_valid && live[sc_player];   // idle seats ignored
    assign time_wide = {1'b0, time_q[sc_player]} + 11'(sc_time);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            players_q     <= 3'd4;
            scores.update <= 1'b0;
            scores.clear  <= 1'b0;
            for (int i = 0; i < review_pkg::NUM_PLAYERS; i++) begin
                count_q[i] <= '0;
                time_q[i]  <= '0;
            end
        end else begin
            scores.update <= 1'b0;
            scores.clear  <= sc_clear;
            if (sc_clear) begin
                for (int i = 0; i < review_pkg::NUM_PLAYERS; i++) begin
                    count_q[i] <= '0;
                    time_q[i]  <= '0;
                end
                if (sc_players == 3'd0) begin
                    players_q <= 3'd1;
                end else if (sc_players > 3'd4) begin
                    players_q <= 3'd4;
                end else begin
                    players_q <= sc_players;
                end
            end else if (rec_ok) begin
                scores.update <= 1'b1;
                if (sc_correct && count_q[sc_player] != review_pkg::COUNT_MAX) begin
                    count_q[sc_player] <= count_q[sc_player] + 6'd1;
                end
                if (time_wide > {1'b0, review_pkg::TIME_MAX}) begin
                    time_q[sc_player] <= review_pkg::TIME_MAX;   // saturate
                end else begin
                    time_q[sc_player] <= time_wide[9:0];
                end
            end
        end
    end

endmodule

// File: src/answer_formatter.sv
`timescale 1ns/100ps

module answer_formatter (
    input  logic                 clk,
    input  logic                 arst_n,
    op_result_if.sink            res,
    output logic                 ans_valid,
    output review_pkg::operand_t ans_hi,
    output review_pkg::operand_t ans_lo,
    input  logic                 ans_ready
);

    logic [11:0]          dec;       // hundreds, tens, ones
    review_pkg::operand_t hi_nxt;
    review_pkg::operand_t lo_nxt;

    function automatic logic [11:0] bcd3(input review_pkg::operand_t v);
        logic [3:0] h;
        logic [3:0] t;
        logic [3:0] o;
        h = 4'(v / 8'd100);
        t = 4'((v / 8'd10) % 8'd10);
        o = 4'(v % 8'd10);
        return {h, t, o};
    endfunction

    // one divider shared by decimal conversion and signed magnitude
    assign dec = bcd3(res.value);

    assign res.ready = !ans_valid || ans_ready;

    always_comb begin
        hi_nxt = '0;
        lo_nxt = '0;
        case (res.category)
            review_pkg::cat_convert: begin
                case (res.op)
                    review_pkg::OP_OCT: begin
                        hi_nxt = {2'b00, res.raw_a[7:6], 1'b0, res.raw_a[5:3]};
                        lo_nxt = {1'b0, res.raw_a[2:0], 4'h0};
                    end
                    review_pkg::OP_DEC: begin
                        hi_nxt = dec[11:4];
                        lo_nxt = {dec[3:0], 4'h0};
                    end
                    review_pkg::OP_HEX: hi_nxt = res.raw_a;   // nibbles are the digits
                    default: ;
                endcase
            end
            review_pkg::cat_signed: begin
                hi_nxt = {res.negative, 3'b000, dec[11:8]};
                lo_nxt = dec[7:0];
            end
            review_pkg::cat_shift,
            review_pkg::cat_bitwise,
            review_pkg::cat_logic: hi_nxt = res.value;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ans_valid <= 1'b0;
        end else if (res.ready) begin
            ans_valid <= res.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid && res.ready) begin
            ans_hi <= hi_nxt;
            ans_lo <= lo_nxt;
        end
    end

    a_no_drop: assert property (@(posedge clk) disable iff (!arst_n)
        ans_valid && !ans_ready |=> ans_valid);

endmodule

// File: src/operation_unit.sv
`timescale 1ns/100ps

module operation_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 q_valid,
    output logic                 q_ready,
    input  logic [2:0]           q_category,
    input  review_pkg::op_sel_t  q_op,
    input  review_pkg::operand_t q_a,
    input  review_pkg::operand_t q_b,
    op_result_if.source          res
);

    review_pkg::category_e cat;
    review_pkg::operand_t  sum;
    review_pkg::operand_t  value_nxt;
    logic                  neg_nxt;
    logic                  a_true;
    logic                  b_true;

    assign cat     = review_pkg::category_e'(q_category);
    assign q_ready = !res.valid || res.ready;   // empty slot or draining
    assign sum     = (q_op == review_pkg::OP_SUB) ? q_a - q_b : q_a + q_b;
    assign a_true  = |q_a;
    assign b_true  = |q_b;

    always_comb begin
        value_nxt = '0;
        neg_nxt   = 1'b0;
        case (cat)
            review_pkg::cat_convert: value_nxt = q_a;
            review_pkg::cat_signed: begin
                if (q_op == review_pkg::OP_ADD || q_op == review_pkg::OP_SUB) begin
                    neg_nxt   = sum[7];
                    value_nxt = sum[7] ? -sum : sum;   // 8'h80 reads as 128
                end
            end
            review_pkg::cat_shift: begin
                // shifts of 8 or more empty the byte, asr leaves sign fill
                case (q_op)
                    review_pkg::OP_ASL,
                    review_pkg::OP_LSL: value_nxt = q_a << q_b;   // left shifts agree
                    review_pkg::OP_ASR: value_nxt = review_pkg::operand_t'($signed(q_a) >>> q_b);
                    default:            value_nxt = q_a >> q_b;
                endcase
            end
            review_pkg::cat_bitwise: begin
                case (q_op)
                    review_pkg::OP_AND: value_nxt = q_a & q_b;
                    review_pkg::OP_OR:  value_nxt = q_a | q_b;
                    review_pkg::OP_NOT: value_nxt = ~q_a;
                    default:            value_nxt = q_a ^ q_b;
                endcase
            end
            review_pkg::cat_logic: begin
                case (q_op)
                    review_pkg::OP_AND: value_nxt = {8{a_true && b_true}};
                    review_pkg::OP_OR:  value_nxt = {8{a_true || b_true}};
                    review_pkg::OP_NOT: value_nxt = {8{!a_true}};
                    default:            value_nxt = {8{a_true ^ b_true}};
                endcase
            end
            default: value_nxt = '0;   // unused codes answer zero
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res.valid <= 1'b0;
        end else if (q_ready) begin
            res.valid <= q_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (q_valid && q_ready) begin
            res.category <= cat;
            res.op       <= q_op;
            res.value    <= value_nxt;
            res.negative <= neg_nxt;
            res.raw_a    <= q_a;
        end
    end

    // a stalled slot keeps its payload until the formatter takes it
    a_slot_hold: assert property (@(posedge clk) disable iff (!arst_n)
        res.valid && !res.ready |=> res.valid &&
        $stable({res.category, res.op, res.value, res.negative, res.raw_a}));

endmodule

// File: src/score_if.sv
`timescale 1ns/100ps

interface score_if;

    review_pkg::count_t                 count      [review_pkg::NUM_PLAYERS];
    review_pkg::time_t                  total_time [review_pkg::NUM_PLAYERS];
    logic [review_pkg::NUM_PLAYERS-1:0] live;    // below latched player count
    logic                               update;  // one cycle after a record lands
    logic                               clear;   // one cycle after scores cleared

    modport source (
        output count, total_time, live, update, clear
    );

    modport sink (
        input  count, total_time, live, update, clear
    );

endinterface

// File: src/op_result_if.sv
`timescale 1ns/100ps

interface op_result_if;

    logic                  valid;
    logic                  ready;     // driven by the formatter
    review_pkg::category_e category;
    review_pkg::op_sel_t   op;
    review_pkg::operand_t  value;     // result, or magnitude for signed
    logic                  negative;
    review_pkg::operand_t  raw_a;     // operand a as received

    modport source (
        output valid, category, op, value, negative, raw_a,
        input  ready
    );

    modport sink (
        input  valid, category, op, value, negative, raw_a,
        output ready
    );

endinterface

// File: src/review_pkg.sv
package review_pkg;

    typedef logic [7:0] operand_t;      // operand or answer byte
    typedef logic [1:0] op_sel_t;       // operation inside a category
    typedef logic [1:0] player_id_t;
    typedef logic [5:0] count_t;        // correct answers
    typedef logic [9:0] time_t;         // accumulated answer time
    typedef logic [4:0] answer_time_t;  // time of a single answer

    typedef enum logic [2:0] {
        cat_none    = 3'd0,
        cat_convert = 3'd1,
        cat_signed  = 3'd2,
        cat_shift   = 3'd3,
        cat_bitwise = 3'd4,
        cat_logic   = 3'd5
    } category_e;

    localparam int     NUM_PLAYERS = 4;
    localparam count_t COUNT_MAX   = 6'd63;
    localparam time_t  TIME_MAX    = 10'd1023;

    // conversion
    localparam op_sel_t OP_OCT = 2'd0;
    localparam op_sel_t OP_DEC = 2'd1;
    localparam op_sel_t OP_HEX = 2'd2;

    // signed arithmetic
    localparam op_sel_t OP_ADD = 2'd0;
    localparam op_sel_t OP_SUB = 2'd1;

    // shifts
    localparam op_sel_t OP_ASL = 2'd0;
    localparam op_sel_t OP_ASR = 2'd1;
    localparam op_sel_t OP_LSL = 2'd2;
    localparam op_sel_t OP_LSR = 2'd3;

    // bitwise and logical share one code set
    localparam op_sel_t OP_AND = 2'd0;
    localparam op_sel_t OP_OR  = 2'd1;
    localparam op_sel_t OP_NOT = 2'd2;
    localparam op_sel_t OP_XOR = 2'd3;

endpackage
